// File: design/emulib_macros.svh
`ifndef EMULIB_MACROS_SVH
`define EMULIB_MACROS_SVH

// trace records buffered between the model and the host
`define EMULIB_TRACE_DEPTH 16

// host command words waiting for the model to pick them up
`define EMULIB_CMD_DEPTH 4

// cycle timestamp width, the counter wraps silently at this size
`define EMULIB_TS_WIDTH 23

`endif

// File: design/emulib_pkg.sv
`include "emulib_macros.svh"

package emulib_pkg;

    // one trace record, the host reads evt_data first and the upper half after it
    typedef struct packed {
        logic                        ovf;
        logic [`EMULIB_TS_WIDTH-1:0] ts;
        logic [7:0]                  evt_id;
        logic [31:0]                 evt_data;
    } trace_rec_t;

    // command word written by the host into the mailbox
    typedef logic [15:0] cmd_t;

endpackage

// File: design/emulib_fifo.sv
`timescale 1ns/100ps

module emulib_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic clk,
    input  logic rst,

    input  logic winc,
    output logic wfull,
    input  T     wdata,

    input  logic rinc,
    output logic rempty,
    output T     rdata
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

    T              mem [DEPTH];
    logic [AW-1:0] wp;
    logic [AW-1:0] rp;
    logic [AW-1:0] wp_next;
    logic [AW-1:0] rp_next;
    logic          wfire;
    logic          rfire;

    assign wfire = winc && !wfull;
    assign rfire = rinc && !rempty;

    // pointers wrap explicitly so DEPTH need not be a power of two
    assign wp_next = (wp == PTR_LAST) ? '0 : wp + 1'b1;
    assign rp_next = (rp == PTR_LAST) ? '0 : rp + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            wp <= '0;
            rp <= '0;
        end else begin
            if (wfire) begin
                wp <= wp_next;
            end
            if (rfire) begin
                rp <= rp_next;
            end
        end
    end

    // a read always frees a slot, and full is only reached by a write catching up
    always_ff @(posedge clk) begin
        if (rst) begin
            wfull <= 1'b0;
        end else if (rfire) begin
            wfull <= 1'b0;
        end else if (wfire && wp_next == rp) begin
            wfull <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rempty <= 1'b1;
        end else if (wfire) begin
            rempty <= 1'b0;
        end else if (rfire && rp_next == wp) begin
            rempty <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wfire) begin
            mem[wp] <= wdata;
        end
    end

    // rdata keeps the last popped entry until the next pop
    always_ff @(posedge clk) begin
        if (rfire) begin
            rdata <= mem[rp];
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(wfull && rempty))
        else $error("fifo flags full and empty at the same time");

    a_empty_after_reset: assert property (@(posedge clk) rst |=> rempty)
        else $error("fifo not empty after reset");

endmodule

// File: design/emulib_event_stamper.sv
`timescale 1ns/100ps
`include "emulib_macros.svh"

module emulib_event_stamper (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   evt_strobe,
    input  logic [7:0]             evt_id,
    input  logic [31:0]            evt_data,

    input  logic                   full,
    output logic                   push,
    output emulib_pkg::trace_rec_t rec
);

    logic [`EMULIB_TS_WIDTH-1:0] ts_cnt;
    logic                        lost;

    // free running cycle count, zero at the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // remembers that events were dropped until a record gets through to carry it
    always_ff @(posedge clk) begin
        if (rst) begin
            lost <= 1'b0;
        end else if (push) begin
            lost <= 1'b0;
        end else if (evt_strobe && full) begin
            lost <= 1'b1;
        end
    end

    assign push = evt_strobe && !full;

    assign rec.ovf      = lost;
    assign rec.ts       = ts_cnt;
    assign rec.evt_id   = evt_id;
    assign rec.evt_data = evt_data;

    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("record pushed into a full trace fifo");

endmodule

// File: design/emulib_host_reader.sv
`timescale 1ns/100ps

module emulib_host_reader (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fifo_empty,
    output logic                   fifo_pop,
    input  emulib_pkg::trace_rec_t fifo_rec,

    input  logic                   host_rd,
    output logic                   host_avail,
    output logic [31:0]            host_word
);

    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_word0,
        s_word1
    } state_t;

    state_t                 state;
    emulib_pkg::trace_rec_t rec_buf;

    // one record in flight at a time, the next pop waits for the host
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (!fifo_empty) begin
                        state <= s_load;
                    end
                end
                s_load: begin
                    state <= s_word0;
                end
                s_word0: begin
                    if (host_rd) begin
                        state <= s_word1;
                    end
                end
                s_word1: begin
                    if (host_rd) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // fifo rdata is valid in load, one edge after the pop
    always_ff @(posedge clk) begin
        if (state == s_load) begin
            rec_buf <= fifo_rec;
        end
    end

    assign fifo_pop   = (state == s_idle) && !fifo_empty;
    assign host_avail = (state == s_word0) || (state == s_word1);

    // word 1 is the upper half, holding ovf, ts and evt_id
    assign host_word = (state == s_word1) ? rec_buf[63:32] : rec_buf.evt_data;

    a_pop_from_idle: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> (state == s_idle) ##2 host_avail)
        else $error("trace pop outside idle or record not presented");

endmodule

// File: design/emulib_trace_unit.sv
`timescale 1ns/100ps
`include "emulib_macros.svh"

module emulib_trace_unit (
    input  logic             clk,
    input  logic             rst,

    // event strobes from the emulated model
    input  logic             evt_strobe,
    input  logic [7:0]       evt_id,
    input  logic [31:0]      evt_data,

    // host side of the trace channel
    input  logic             host_rd,
    output logic             host_avail,
    output logic [31:0]      host_word,

    // host side of the command mailbox
    input  logic             host_cmd_wr,
    input  emulib_pkg::cmd_t host_cmd,
    output logic             host_cmd_full,

    // model side of the command mailbox
    input  logic             cmd_rd,
    output logic             cmd_valid,
    output emulib_pkg::cmd_t cmd_word
);

    logic                   trace_push;
    logic                   trace_full;
    emulib_pkg::trace_rec_t trace_wrec;
    logic                   trace_pop;
    logic                   trace_empty;
    emulib_pkg::trace_rec_t trace_rrec;
    logic                   cmd_empty;

    emulib_event_stamper u_event_stamper (
        .clk        (clk),
        .rst        (rst),
        .evt_strobe (evt_strobe),
        .evt_id     (evt_id),
        .evt_data   (evt_data),
        .full       (trace_full),
        .push       (trace_push),
        .rec        (trace_wrec)
    );

    emulib_fifo #(
        .T     (emulib_pkg::trace_rec_t),
        .DEPTH (`EMULIB_TRACE_DEPTH)
    ) u_trace_fifo (
        .clk    (clk),
        .rst    (rst),
        .winc   (trace_push),
        .wfull  (trace_full),
        .wdata  (trace_wrec),
        .rinc   (trace_pop),
        .rempty (trace_empty),
        .rdata  (trace_rrec)
    );

    emulib_host_reader u_host_reader (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (trace_empty),
        .fifo_pop   (trace_pop),
        .fifo_rec   (trace_rrec),
        .host_rd    (host_rd),
        .host_avail (host_avail),
        .host_word  (host_word)
    );

    emulib_fifo #(
        .T     (emulib_pkg::cmd_t),
        .DEPTH (`EMULIB_CMD_DEPTH)
    ) u_cmd_fifo (
        .clk    (clk),
        .rst    (rst),
        .winc   (host_cmd_wr),
        .wfull  (host_cmd_full),
        .wdata  (host_cmd),
        .rinc   (cmd_rd),
        .rempty (cmd_empty),
        .rdata  (cmd_word)
    );

    assign cmd_valid = !cmd_empty;

endmodule

// File: verification/emulib_trace_unit_tb.sv
`timescale 1ns/100ps
`include "emulib_macros.svh"

module emulib_trace_unit_tb;

    // 30 trace records, each taking at most the polling limit plus a few
    // handshake cycles, and a short mailbox test fit well inside this
    localparam int POLL_LIMIT      = 40;
    localparam int WATCHDOG_CYCLES = 3000;

    logic             clk;
    logic             rst;
    logic             evt_strobe;
    logic [7:0]       evt_id;
    logic [31:0]      evt_data;
    logic             host_rd;
    logic             host_avail;
    logic [31:0]      host_word;
    logic             host_cmd_wr;
    logic [15:0]      host_cmd;
    logic             host_cmd_full;
    logic             cmd_rd;
    logic             cmd_valid;
    logic [15:0]      cmd_word;

    logic [`EMULIB_TS_WIDTH-1:0] cyc;
    logic [31:0]                 lcg_state;
    logic [31:0]                 exp_lo [$];
    logic [31:0]                 exp_hi [$];

    emulib_trace_unit u_emulib_trace_unit (
        .clk           (clk),
        .rst           (rst),
        .evt_strobe    (evt_strobe),
        .evt_id        (evt_id),
        .evt_data      (evt_data),
        .host_rd       (host_rd),
        .host_avail    (host_avail),
        .host_word     (host_word),
        .host_cmd_wr   (host_cmd_wr),
        .host_cmd      (host_cmd),
        .host_cmd_full (host_cmd_full),
        .cmd_rd        (cmd_rd),
        .cmd_valid     (cmd_valid),
        .cmd_word      (cmd_word)
    );

    always #50 clk = ~clk;

    // counts edges out of reset, so at a falling edge it holds the timestamp
    // that the next rising edge stamps on a record
    always @(posedge clk) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic wait_avail(input int limit);
        int n;
        n = 0;
        while (!host_avail && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!host_avail) begin
            abort_run($sformatf("no trace record reached the host within %0d cycles", limit));
        end
    endtask

    // drives one strobe for the coming rising edge and records what the host should see
    task automatic send_event(input logic [7:0] id, input logic [31:0] data,
                              input logic accept, input logic ovf);
        @(negedge clk);
        evt_strobe = 1'b1;
        evt_id     = id;
        evt_data   = data;
        if (accept) begin
            exp_lo.push_back(data);
            exp_hi.push_back({ovf, cyc, id});
        end
    endtask

    task automatic send_rand_event(input logic accept, input logic ovf);
        logic [31:0] r;
        logic [31:0] d;
        r = next_rand();
        d = next_rand();
        send_event(r[23:16], d, accept, ovf);
    endtask

    task automatic stop_events();
        @(negedge clk);
        evt_strobe = 1'b0;
    endtask

    task automatic read_expected(output logic [31:0] hi_got);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = exp_lo.pop_front();
        hi = exp_hi.pop_front();
        wait_avail(POLL_LIMIT);
        check_equal("host_word0", 64'(host_word), 64'(lo));
        host_rd = 1'b1;
        @(negedge clk);
        check_equal("host_avail", 64'(host_avail), 64'(1));
        check_equal("host_word1", 64'(host_word), 64'(hi));
        hi_got = host_word;
        @(negedge clk);
        host_rd = 1'b0;
    endtask

    task automatic drain_and_settle();
        logic [31:0] hi;
        while (exp_lo.size() > 0) begin
            read_expected(hi);
        end
        repeat (4) @(negedge clk);
        check_equal("host_avail", 64'(host_avail), 64'(0));
    endtask

    task automatic test_reset();
        check_equal("host_avail", 64'(host_avail), 64'(0));
        check_equal("cmd_valid", 64'(cmd_valid), 64'(0));
        check_equal("host_cmd_full", 64'(host_cmd_full), 64'(0));
    endtask

    task automatic test_single_event();
        logic [31:0] hi;
        send_rand_event(1'b1, 1'b0);
        stop_events();
        // with the path idle the record shows up on the third edge after the event
        check_equal("host_avail", 64'(host_avail), 64'(0));
        @(negedge clk);
        check_equal("host_avail", 64'(host_avail), 64'(0));
        @(negedge clk);
        check_equal("host_avail", 64'(host_avail), 64'(1));
        read_expected(hi);
        drain_and_settle();
    endtask

    task automatic test_burst_order();
        logic [31:0]                 hi;
        logic [`EMULIB_TS_WIDTH-1:0] prev_ts;
        repeat (10) send_rand_event(1'b1, 1'b0);
        stop_events();
        for (int i = 0; i < 10; i++) begin
            read_expected(hi);
            if (i > 0) begin
                check_equal("ts_increasing", 64'(hi[30:8] > prev_ts), 64'(1));
            end
            prev_ts = hi[30:8];
        end
        drain_and_settle();
    endtask

    task automatic test_overflow();
        logic [31:0] hi;
        // the reader pulls the first record out one edge after it lands, so one
        // record more than the fifo depth is taken before the rest are dropped
        for (int i = 0; i < `EMULIB_TRACE_DEPTH + 4; i++) begin
            send_rand_event(i < `EMULIB_TRACE_DEPTH + 1, 1'b0);
        end
        stop_events();
        read_expected(hi);
        wait_avail(POLL_LIMIT);
        send_rand_event(1'b1, 1'b1);
        stop_events();
        read_expected(hi);
        wait_avail(POLL_LIMIT);
        send_rand_event(1'b1, 1'b0);
        stop_events();
        drain_and_settle();
    endtask

    task automatic test_cmd_mailbox();
        logic [15:0] cmds [4];
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            cmds[i] = r[31:16];
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            host_cmd_wr = 1'b1;
            host_cmd    = cmds[i];
        end
        @(negedge clk);
        check_equal("host_cmd_full", 64'(host_cmd_full), 64'(1));
        // a fifth word while full must be ignored
        host_cmd = ~cmds[3];
        @(negedge clk);
        host_cmd_wr = 1'b0;
        check_equal("host_cmd_full", 64'(host_cmd_full), 64'(1));
        for (int i = 0; i < 4; i++) begin
            check_equal("cmd_valid", 64'(cmd_valid), 64'(1));
            cmd_rd = 1'b1;
            @(negedge clk);
            check_equal("cmd_word", 64'(cmd_word), 64'(cmds[i]));
        end
        cmd_rd = 1'b0;
        check_equal("cmd_valid", 64'(cmd_valid), 64'(0));
        check_equal("host_cmd_full", 64'(host_cmd_full), 64'(0));
        cmd_rd = 1'b1;
        @(negedge clk);
        cmd_rd = 1'b0;
        check_equal("cmd_valid", 64'(cmd_valid), 64'(0));
        check_equal("cmd_word", 64'(cmd_word), 64'(cmds[3]));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout, the tests did not finish in %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        evt_strobe  = 1'b0;
        evt_id      = '0;
        evt_data    = '0;
        host_rd     = 1'b0;
        host_cmd_wr = 1'b0;
        host_cmd    = '0;
        cmd_rd      = 1'b0;
        lcg_state   = 32'h6fb8_9d2b;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_single_event();
        test_burst_order();
        test_overflow();
        test_cmd_mailbox();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/emulib_pkg.sv
design/emulib_fifo.sv
design/emulib_event_stamper.sv
design/emulib_host_reader.sv
design/emulib_trace_unit.sv
verification/emulib_trace_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/100ps \
    --top-module emulib_trace_unit_tb \
    --Mdir obj_dir \
    -f compile.f

# the binary exits with an error on a failed check, the log decides the result
./obj_dir/Vemulib_trace_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: passed"
    exit 0
else
    echo "run_sim: failed, see sim.log"
    exit 1
fi
